/* source/llc_pkg.sv */
/*
 * LLC slice geometry and field types
 */

`default_nettype none

package llc_pkg;

    // cache geometry
    localparam int LLC_WAYS       = 4;
    localparam int LLC_WAY_BITS   = $clog2(LLC_WAYS);
    localparam int LLC_SETS       = 64;
    localparam int LLC_SET_BITS   = $clog2(LLC_SETS);

    // per-way field widths
    localparam int LLC_TAG_BITS   = 12;
    localparam int LLC_STATE_BITS = 3;
    localparam int LLC_LINE_BITS  = 128;

    // set index into every per-way array and the eviction array
    typedef logic [LLC_SET_BITS-1:0] llc_set_t;

    // way index, also stored per set as the eviction pointer
    typedef logic [LLC_WAY_BITS-1:0] llc_way_t;

    // address tag kept for each way
    typedef logic [LLC_TAG_BITS-1:0] llc_tag_t;

    // coherence state code, meaning is up to the controller
    typedef logic [LLC_STATE_BITS-1:0] llc_state_t;

    // one full data line
    typedef logic [LLC_LINE_BITS-1:0] line_t;

endpackage

`default_nettype wire

/* source/llc_wr_decode.sv */
/*
 * LLC way write enable decoder
 */

`timescale 1ns/1ps
`default_nettype none

module llc_wr_decode
    import llc_pkg::*;
(
    input  logic                wr_en,
    input  llc_way_t            way,
    input  logic [LLC_WAYS-1:0] wr_rst_flush,

    output logic [LLC_WAYS-1:0] wr_en_meta,
    output logic [LLC_WAYS-1:0] wr_en_data
);

    // one-hot form of the way select, qualified by the write strobe
    logic [LLC_WAYS-1:0] way_hit;

    always_comb begin
        for (int i = 0; i < LLC_WAYS; i++) begin
            way_hit[i] = (way == llc_way_t'(i));
        end
    end

    // tag and line follow the way select only
    always_comb begin
        for (int i = 0; i < LLC_WAYS; i++) begin
            wr_en_data[i] = wr_en & way_hit[i];
        end
    end

    // state and dirty bit also take the flush vector,
    // a flagged way is written no matter what way points at
    always_comb begin
        for (int i = 0; i < LLC_WAYS; i++) begin
            wr_en_meta[i] = wr_en_data[i] | wr_rst_flush[i];
        end
    end

endmodule

`default_nettype wire

/* source/llc_way_store.sv */
/*
 * LLC single way storage
 */

`timescale 1ns/1ps
`default_nettype none

module llc_way_store
    import llc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // read side
    input  logic       rd_en,
    input  llc_set_t   set_in,

    // write side
    input  logic       wr_en_meta,
    input  logic       wr_en_data,
    input  llc_tag_t   wr_data_tag,
    input  llc_state_t wr_data_state,
    input  logic       wr_data_dirty_bit,
    input  line_t      wr_data_line,

    output llc_tag_t   rd_data_tag,
    output llc_state_t rd_data_state,
    output logic       rd_data_dirty_bit,
    output line_t      rd_data_line
);

    // one array per field, indexed by set
    llc_tag_t   tag_mem   [LLC_SETS];
    llc_state_t state_mem [LLC_SETS];
    logic       dirty_mem [LLC_SETS];
    line_t      line_mem  [LLC_SETS];

    // state and dirty bit, written by a way write or a flush
    always_ff @(posedge clk) begin
        if (wr_en_meta) begin
            state_mem[set_in] <= wr_data_state;
            dirty_mem[set_in] <= wr_data_dirty_bit;
        end
    end

    // tag and line, only on a way write
    always_ff @(posedge clk) begin
        if (wr_en_data) begin
            tag_mem[set_in]  <= wr_data_tag;
            line_mem[set_in] <= wr_data_line;
        end
    end

    // registered read, sees the array before a same-edge write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_tag       <= '0;
            rd_data_state     <= '0;
            rd_data_dirty_bit <= 1'b0;
        end else if (rd_en) begin
            rd_data_tag       <= tag_mem[set_in];
            rd_data_state     <= state_mem[set_in];
            rd_data_dirty_bit <= dirty_mem[set_in];
        end
    end

    // line register kept apart, it is by far the widest
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_line <= '0;
        end else if (rd_en) begin
            rd_data_line <= line_mem[set_in];
        end
    end

endmodule

`default_nettype wire

/* source/llc_evict_store.sv */
/*
 * LLC eviction way pointer storage
 */

`timescale 1ns/1ps
`default_nettype none

module llc_evict_store
    import llc_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rd_en,
    input  llc_set_t set_in,

    input  logic     wr_en_evict_way,
    input  llc_way_t wr_data_evict_way,

    output llc_way_t rd_data_evict_way
);

    // next victim way, one entry per set
    llc_way_t evict_mem [LLC_SETS];

    always_ff @(posedge clk) begin
        if (wr_en_evict_way) begin
            evict_mem[set_in] <= wr_data_evict_way;
        end
    end

    // read-first, holds while rd_en is low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_data_evict_way <= '0;
        end else if (rd_en) begin
            rd_data_evict_way <= evict_mem[set_in];
        end
    end

endmodule

`default_nettype wire

/* source/llc_localmem.sv */
/*
 * LLC slice local memory
 */

`timescale 1ns/1ps
`default_nettype none

module llc_localmem
    import llc_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    // read command
    input  logic                  rd_en,
    input  llc_set_t              set_in,

    // way write and flush
    input  logic                  wr_en,
    input  llc_way_t              way,
    input  logic [LLC_WAYS-1:0]   wr_rst_flush,
    input  llc_tag_t              wr_data_tag,
    input  llc_state_t            wr_data_state,
    input  logic                  wr_data_dirty_bit,
    input  line_t                 wr_data_line,

    // eviction pointer write
    input  logic                  wr_en_evict_way,
    input  llc_way_t              wr_data_evict_way,

    // all ways of the set, index is the way
    output llc_tag_t   [LLC_WAYS-1:0] rd_data_tag,
    output llc_state_t [LLC_WAYS-1:0] rd_data_state,
    output logic       [LLC_WAYS-1:0] rd_data_dirty_bit,
    output line_t      [LLC_WAYS-1:0] rd_data_line,
    output llc_way_t                  rd_data_evict_way
);

    logic [LLC_WAYS-1:0] wr_en_meta;
    logic [LLC_WAYS-1:0] wr_en_data;

    llc_wr_decode i_llc_wr_decode (
        .wr_en        (wr_en),
        .way          (way),
        .wr_rst_flush (wr_rst_flush),
        .wr_en_meta   (wr_en_meta),
        .wr_en_data   (wr_en_data)
    );

    // set index and write data go to every way unchanged
    for (genvar g = 0; g < LLC_WAYS; g++) begin : g_way
        llc_way_store i_llc_way_store (
            .clk               (clk),
            .rst_n             (rst_n),
            .rd_en             (rd_en),
            .set_in            (set_in),
            .wr_en_meta        (wr_en_meta[g]),
            .wr_en_data        (wr_en_data[g]),
            .wr_data_tag       (wr_data_tag),
            .wr_data_state     (wr_data_state),
            .wr_data_dirty_bit (wr_data_dirty_bit),
            .wr_data_line      (wr_data_line),
            .rd_data_tag       (rd_data_tag[g]),
            .rd_data_state     (rd_data_state[g]),
            .rd_data_dirty_bit (rd_data_dirty_bit[g]),
            .rd_data_line      (rd_data_line[g])
        );
    end

    llc_evict_store i_llc_evict_store (
        .clk               (clk),
        .rst_n             (rst_n),
        .rd_en             (rd_en),
        .set_in            (set_in),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data_evict_way (rd_data_evict_way)
    );

endmodule

`default_nettype wire

/* tb/llc_localmem_props.sv */
/*
 * LLC local memory properties
 */

`timescale 1ns/1ps
`default_nettype none

module llc_localmem_props
    import llc_pkg::*;
(
    input logic                      clk,
    input logic                      rst_n,
    input logic                      rd_en,
    input logic                      wr_en,
    input logic                      wr_en_evict_way,
    input logic [LLC_WAYS-1:0]       wr_rst_flush,
    input llc_set_t                  set_in,
    input llc_tag_t   [LLC_WAYS-1:0] rd_data_tag,
    input llc_state_t [LLC_WAYS-1:0] rd_data_state,
    input logic       [LLC_WAYS-1:0] rd_data_dirty_bit,
    input line_t      [LLC_WAYS-1:0] rd_data_line,
    input llc_way_t                  rd_data_evict_way
);

    logic [LLC_WAYS*(LLC_TAG_BITS+LLC_STATE_BITS+1+LLC_LINE_BITS)+LLC_WAY_BITS-1:0] rd_all;

    assign rd_all = {rd_data_tag, rd_data_state, rd_data_dirty_bit, rd_data_line,
                     rd_data_evict_way};

    a_set_known: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_en || wr_en || wr_en_evict_way || (|wr_rst_flush)) |-> !$isunknown(set_in))
        else $error("set index unknown while a strobe is high");

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_en |=> $stable(rd_all))
        else $error("read outputs changed without a read");

    a_reset_zero: assert property (@(posedge clk) !rst_n |=> (rd_all == '0))
        else $error("read outputs not cleared by reset");

endmodule

bind llc_localmem llc_localmem_props i_llc_localmem_props (.*);

`default_nettype wire

/* tb/llc_localmem_tb.sv */
/*
 * LLC local memory testbench
 */

`timescale 1ns/1ps
`default_nettype none

module llc_localmem_tb
    import llc_pkg::*;
;

    logic                      clk;
    logic                      rst_n;
    logic                      rd_en;
    llc_set_t                  set_in;
    logic                      wr_en;
    llc_way_t                  way;
    logic [LLC_WAYS-1:0]       wr_rst_flush;
    llc_tag_t                  wr_data_tag;
    llc_state_t                wr_data_state;
    logic                      wr_data_dirty_bit;
    line_t                     wr_data_line;
    logic                      wr_en_evict_way;
    llc_way_t                  wr_data_evict_way;
    llc_tag_t   [LLC_WAYS-1:0] rd_data_tag;
    llc_state_t [LLC_WAYS-1:0] rd_data_state;
    logic       [LLC_WAYS-1:0] rd_data_dirty_bit;
    line_t      [LLC_WAYS-1:0] rd_data_line;
    llc_way_t                  rd_data_evict_way;

    // reference contents of every way and set
    llc_tag_t   tag_model   [LLC_WAYS][LLC_SETS];
    llc_state_t state_model [LLC_WAYS][LLC_SETS];
    logic       dirty_model [LLC_WAYS][LLC_SETS];
    line_t      line_model  [LLC_WAYS][LLC_SETS];
    llc_way_t   evict_model [LLC_SETS];

    // eviction pointers written so far
    logic       evict_known [LLC_SETS];

    // expected read outputs of one set
    llc_tag_t   exp_tag       [LLC_WAYS];
    llc_state_t exp_state     [LLC_WAYS];
    logic       exp_dirty     [LLC_WAYS];
    line_t      exp_line      [LLC_WAYS];
    llc_way_t   exp_evict;
    logic       exp_evict_known;

    llc_localmem i_llc_localmem (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
    end

    initial begin
        for (int i = 0; i < 5000; i++) begin
            @(posedge clk);
        end
        fail_run("watchdog expired, the run did not finish within 5000 cycles");
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input line_t actual, input line_t expected);
        if (actual !== expected) begin
            fail_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_inputs();
        rd_en             = 1'b0;
        set_in            = '0;
        wr_en             = 1'b0;
        way               = '0;
        wr_rst_flush      = '0;
        wr_data_tag       = '0;
        wr_data_state     = '0;
        wr_data_dirty_bit = 1'b0;
        wr_data_line      = '0;
        wr_en_evict_way   = 1'b0;
        wr_data_evict_way = '0;
    endtask

    task automatic clear_model();
        for (int s = 0; s < LLC_SETS; s++) begin
            evict_known[s] = 1'b0;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles == 20) begin
                fail_run("reset was not released within 20 cycles");
            end
            @(posedge clk);
            cycles++;
        end
        #1;
    endtask

    task automatic write_way(input llc_set_t s, input llc_way_t w, input llc_tag_t tag,
                             input llc_state_t state, input logic dirty, input line_t line);
        set_in            = s;
        way               = w;
        wr_en             = 1'b1;
        wr_data_tag       = tag;
        wr_data_state     = state;
        wr_data_dirty_bit = dirty;
        wr_data_line      = line;
        next_cycle();
        wr_en = 1'b0;
        tag_model[w][s]   = tag;
        state_model[w][s] = state;
        dirty_model[w][s] = dirty;
        line_model[w][s]  = line;
    endtask

    task automatic write_random_way(input llc_set_t s, input llc_way_t w);
        write_way(s, w, llc_tag_t'($urandom()), llc_state_t'($urandom()), 1'($urandom()),
                  {$urandom(), $urandom(), $urandom(), $urandom()});
    endtask

    // tag, line and way carry noise that a flush must ignore
    task automatic flush_ways(input llc_set_t s, input logic [LLC_WAYS-1:0] flags,
                              input llc_state_t state, input logic dirty);
        set_in            = s;
        way               = llc_way_t'($urandom());
        wr_rst_flush      = flags;
        wr_data_state     = state;
        wr_data_dirty_bit = dirty;
        wr_data_tag       = llc_tag_t'($urandom());
        wr_data_line      = {$urandom(), $urandom(), $urandom(), $urandom()};
        next_cycle();
        wr_rst_flush = '0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            if (flags[w]) begin
                state_model[w][s] = state;
                dirty_model[w][s] = dirty;
            end
        end
    endtask

    task automatic write_evict(input llc_set_t s, input llc_way_t ptr);
        set_in            = s;
        wr_en_evict_way   = 1'b1;
        wr_data_evict_way = ptr;
        next_cycle();
        wr_en_evict_way = 1'b0;
        evict_model[s]  = ptr;
        evict_known[s]  = 1'b1;
    endtask

    task automatic load_expected(input llc_set_t s);
        for (int w = 0; w < LLC_WAYS; w++) begin
            exp_tag[w]   = tag_model[w][s];
            exp_state[w] = state_model[w][s];
            exp_dirty[w] = dirty_model[w][s];
            exp_line[w]  = line_model[w][s];
        end
        exp_evict       = evict_model[s];
        exp_evict_known = evict_known[s];
    endtask

    task automatic check_outputs();
        for (int w = 0; w < LLC_WAYS; w++) begin
            check_value($sformatf("rd_data_tag[%0d]", w),
                        line_t'(rd_data_tag[w]), line_t'(exp_tag[w]));
            check_value($sformatf("rd_data_state[%0d]", w),
                        line_t'(rd_data_state[w]), line_t'(exp_state[w]));
            check_value($sformatf("rd_data_dirty_bit[%0d]", w),
                        line_t'(rd_data_dirty_bit[w]), line_t'(exp_dirty[w]));
            check_value($sformatf("rd_data_line[%0d]", w), rd_data_line[w], exp_line[w]);
        end
        if (exp_evict_known) begin
            check_value("rd_data_evict_way", line_t'(rd_data_evict_way), line_t'(exp_evict));
        end
    endtask

    task automatic read_and_check(input llc_set_t s);
        rd_en  = 1'b1;
        set_in = s;
        next_cycle();
        rd_en = 1'b0;
        load_expected(s);
        check_outputs();
    endtask

    task automatic test_reset_outputs();
        for (int w = 0; w < LLC_WAYS; w++) begin
            check_value($sformatf("rd_data_tag[%0d]", w), line_t'(rd_data_tag[w]), '0);
            check_value($sformatf("rd_data_state[%0d]", w), line_t'(rd_data_state[w]), '0);
            check_value($sformatf("rd_data_dirty_bit[%0d]", w),
                        line_t'(rd_data_dirty_bit[w]), '0);
            check_value($sformatf("rd_data_line[%0d]", w), rd_data_line[w], '0);
        end
        check_value("rd_data_evict_way", line_t'(rd_data_evict_way), '0);
    endtask

    // sets 3, 23, 43 and 63 carry all the traffic
    task automatic test_write_read_sets();
        for (int i = 0; i < 4; i++) begin
            for (int w = 0; w < LLC_WAYS; w++) begin
                write_random_way(llc_set_t'(i * 20 + 3), llc_way_t'(w));
            end
        end
        for (int i = 0; i < 4; i++) begin
            read_and_check(llc_set_t'(i * 20 + 3));
        end
    endtask

    task automatic test_flush();
        llc_state_t                        state;
        logic                              dirty;
        logic [(1 << LLC_STATE_BITS)-1:0]  used;
        used = '0;
        for (int w = 0; w < LLC_WAYS; w++) begin
            used[state_model[w][23]] = 1'b1;
        end
        // a state that no way of the set holds yet
        state = state_model[1][23];
        for (int n = 0; n < (1 << LLC_STATE_BITS); n++) begin
            if (used[state]) begin
                state = state + 3'd1;
            end
        end
        dirty = ~dirty_model[1][23];
        flush_ways(6'd23, 4'b1010, state, dirty);
        read_and_check(6'd23);
        read_and_check(6'd3);
    endtask

    task automatic test_evict_pointer();
        for (int i = 0; i < 4; i++) begin
            write_evict(llc_set_t'(i * 20 + 3), llc_way_t'($urandom()));
        end
        for (int i = 0; i < 4; i++) begin
            read_and_check(llc_set_t'(i * 20 + 3));
        end
        write_random_way(6'd43, 2'd2);
        read_and_check(6'd43);
    endtask

    task automatic test_hold_and_read_first();
        llc_tag_t   tag;
        llc_state_t state;
        line_t      line;
        read_and_check(6'd63);
        // writes with rd_en low must not reach the outputs
        write_random_way(6'd63, 2'd1);
        write_evict(6'd63, ~evict_model[63]);
        next_cycle();
        check_outputs();
        // read and write to the same set at one edge
        load_expected(6'd63);
        tag   = llc_tag_t'($urandom());
        state = llc_state_t'($urandom());
        line  = {$urandom(), $urandom(), $urandom(), $urandom()};
        rd_en = 1'b1;
        set_in = 6'd63;
        wr_en = 1'b1;
        way = 2'd3;
        wr_data_tag = tag;
        wr_data_state = state;
        wr_data_dirty_bit = 1'b1;
        wr_data_line = line;
        next_cycle();
        rd_en = 1'b0;
        wr_en = 1'b0;
        check_outputs();
        tag_model[3][63]   = tag;
        state_model[3][63] = state;
        dirty_model[3][63] = 1'b1;
        line_model[3][63]  = line;
        read_and_check(6'd63);
    endtask

    initial begin
        void'($urandom(82707));
        idle_inputs();
        clear_model();
        wait_reset_release();
        test_reset_outputs();
        test_write_read_sets();
        test_flush();
        test_evict_pointer();
        test_hold_and_read_first();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/llc_pkg.sv
source/llc_wr_decode.sv
source/llc_way_store.sv
source/llc_evict_store.sv
source/llc_localmem.sv
tb/llc_localmem_props.sv
tb/llc_localmem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the llc_localmem testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

TOP=llc_localmem_tb
BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

echo "building ${TOP}"
verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module "${TOP}" \
    --Mdir "${BUILD_DIR}" \
    -f flist.f > "${BUILD_LOG}" 2>&1
status=$?
if [ ${status} -ne 0 ]; then
    cat "${BUILD_LOG}"
    echo "build failed with status ${status}"
    exit 1
fi

if [ ! -x "${BUILD_DIR}/V${TOP}" ]; then
    echo "simulation binary ${BUILD_DIR}/V${TOP} not found"
    exit 1
fi

echo "running ${TOP}"
"./${BUILD_DIR}/V${TOP}" > "${SIM_LOG}" 2>&1
status=$?
cat "${SIM_LOG}"
if [ ${status} -ne 0 ]; then
    echo "simulation exited with status ${status}"
    exit 1
fi

if grep -q "^TESTS PASSED$" "${SIM_LOG}"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, pass message not found in ${SIM_LOG}"
    exit 1
fi
